// File: Makefile
# Verilator build and run for the pipeline trace unit

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= pipe_trace_tb
FILELIST  ?= pipe_trace.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := TEST RESULT: FAIL

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o sim_$(TOP)
	./$(OBJ_DIR)/sim_$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "No result line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/payload_log.sv
////////////////////////////////////////////////////////////////////////////
// Per-slot store of fetch, decode, execute and memory payloads
// Slot is the low bits of seq, in-flight seqs never share a slot
// Read of the write-back slot is combinational, table has no reset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module payload_log (
    input  logic                        clk,
    input  logic                        rst_n,
    input  pipe_trace_pkg::track_t      track,     // Stage valids and seqs
    input  pipe_trace_pkg::stage_in_t   stage_in,  // Live CPU payloads
    output pipe_trace_pkg::retire_rec_t wb_entry   // Partial record for write-back
);

    pipe_trace_pkg::word_t pc_tbl    [pipe_trace_pkg::n_slots];
    pipe_trace_pkg::word_t instr_tbl [pipe_trace_pkg::n_slots];
    pipe_trace_pkg::word_t exec_tbl  [pipe_trace_pkg::n_slots];
    pipe_trace_pkg::word_t addr_tbl  [pipe_trace_pkg::n_slots];
    logic                  f_valid_q;   // Fetch view one cycle back
    pipe_trace_pkg::seq_t  f_seq_q;
    logic                  fetch_new;   // First cycle of this fetch
    pipe_trace_pkg::slot_t f_slot;
    pipe_trace_pkg::slot_t d_slot;
    pipe_trace_pkg::slot_t e_slot;
    pipe_trace_pkg::slot_t m_slot;
    pipe_trace_pkg::slot_t w_slot;

    assign f_slot = track.f_seq[pipe_trace_pkg::slot_w-1:0];
    assign d_slot = track.d_seq[pipe_trace_pkg::slot_w-1:0];
    assign e_slot = track.e_seq[pipe_trace_pkg::slot_w-1:0];
    assign m_slot = track.m_seq[pipe_trace_pkg::slot_w-1:0];
    assign w_slot = track.w_seq[pipe_trace_pkg::slot_w-1:0];

    // New fetch when the slot turns valid or a new seq arrives
    assign fetch_new = track.f_valid && (!f_valid_q || (track.f_seq != f_seq_q));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            f_valid_q <= 1'b0;
            f_seq_q   <= '0;
        end else begin
            f_valid_q <= track.f_valid;
            f_seq_q   <= track.f_seq;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Table writes, one per valid stage
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (fetch_new)     pc_tbl[f_slot]    <= stage_in.fetch_pc;      // Held fetch keeps first pc
        if (track.d_valid) instr_tbl[d_slot] <= stage_in.decode_instr;  // Last decode cycle wins
        if (track.e_valid) exec_tbl[e_slot]  <= stage_in.exec_result;
        if (track.m_valid) addr_tbl[m_slot]  <= stage_in.mem_addr;
    end

    // Write-back slot, seq, stalls and wb_data come from elsewhere
    always_comb begin
        wb_entry             = '0;
        wb_entry.fetch_pc    = pc_tbl[w_slot];
        wb_entry.instr       = instr_tbl[w_slot];
        wb_entry.exec_result = exec_tbl[w_slot];
        wb_entry.mem_addr    = addr_tbl[w_slot];
    end

endmodule

// File: design/pipe_trace_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, vector types and packed records for the pipeline trace
// Eight log slots cover the five instructions that can be in flight
// Sequence numbers wrap at 256, stall counts saturate at stall_max
////////////////////////////////////////////////////////////////////////////
package pipe_trace_pkg;

    // Widths
    localparam int seq_w     = 8;                   // Sequence number
    localparam int slot_w    = 3;                   // Log index, low bits of seq
    localparam int xlen      = 32;                  // Data word
    localparam int stall_w   = 4;                   // Per-instruction stall counter
    localparam int n_slots   = 1 << slot_w;         // Log depth
    localparam int stall_max = (1 << stall_w) - 1;  // Counter saturates here

    // Vector types
    typedef logic [seq_w-1:0]   seq_t;        // Wraps
    typedef logic [slot_w-1:0]  slot_t;
    typedef logic [xlen-1:0]    word_t;
    typedef logic [stall_w-1:0] stall_cnt_t;  // Cycles spent stalled in decode

    // Payloads the CPU presents in one cycle
    typedef struct packed {
        word_t fetch_pc;
        word_t decode_instr;
        word_t exec_result;
        word_t mem_addr;
        word_t wb_data;
    } stage_in_t;

    // Tracker view of the pipe, 49 bits
    typedef struct packed {
        logic       f_valid;
        seq_t       f_seq;
        logic       d_valid;
        seq_t       d_seq;
        logic       e_valid;
        seq_t       e_seq;
        logic       m_valid;
        seq_t       m_seq;
        logic       w_valid;
        seq_t       w_seq;
        stall_cnt_t wb_stalls;  // Stall count of the write-back instruction
    } track_t;

    // One retired instruction, 172 bits
    typedef struct packed {
        seq_t       seq;
        word_t      fetch_pc;
        word_t      instr;        // Last decode cycle value
        word_t      exec_result;
        word_t      mem_addr;
        word_t      wb_data;
        stall_cnt_t stalls;
    } retire_rec_t;

endpackage

// File: design/pipe_trace_top.sv
////////////////////////////////////////////////////////////////////////////
// Pipeline trace unit for a five-stage in-order CPU
// Inputs sampled at each rising edge, stall is level-sensitive
// One retire record per instruction, in fetch order, no back-pressure
// No flush, no out-of-order retire
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pipe_trace_top (
    input  logic                        clk,
    input  logic                        rst_n,         // Sync, active low
    input  logic                        stall,         // Holds fetch and decode
    input  pipe_trace_pkg::stage_in_t   stage_in,      // Per-cycle stage payloads
    output logic                        retire_valid,  // One-cycle retire strobe
    output pipe_trace_pkg::retire_rec_t retire         // Registered retire record
);

    pipe_trace_pkg::track_t      track_w;     // Tracker view to log and assembler
    pipe_trace_pkg::retire_rec_t wb_entry_w;  // Logged payloads of wb slot

    ////////////////////////////////////////////////////////////////////////////
    // Sequence and stall tracking
    ////////////////////////////////////////////////////////////////////////////
    stage_tracker stage_tracker_i (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .track (track_w)
    );

    // Payload store by slot
    payload_log payload_log_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .track    (track_w),
        .stage_in (stage_in),
        .wb_entry (wb_entry_w)
    );

    // wb_data skips the log and goes straight to the record
    retire_assembler retire_assembler_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .track        (track_w),
        .wb_entry     (wb_entry_w),
        .wb_data      (stage_in.wb_data),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

// File: design/retire_assembler.sv
////////////////////////////////////////////////////////////////////////////
// Merges tracker state, log entry and live wb_data into a retire record
// retire_valid pulses one cycle after the write-back cycle
// No back-pressure, the consumer takes every strobe
// Record holds between strobes, it is X until the first one
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module retire_assembler (
    input  logic                        clk,
    input  logic                        rst_n,
    input  pipe_trace_pkg::track_t      track,         // For w_valid, w_seq, wb_stalls
    input  pipe_trace_pkg::retire_rec_t wb_entry,      // Logged payloads of wb slot
    input  pipe_trace_pkg::word_t       wb_data,       // Live write-back payload
    output logic                        retire_valid,  // One-cycle strobe
    output pipe_trace_pkg::retire_rec_t retire
);

    pipe_trace_pkg::retire_rec_t rec_d;

    ////////////////////////////////////////////////////////////////////////////
    // Record merge
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        rec_d         = wb_entry;         // fetch_pc, instr, exec_result, mem_addr
        rec_d.seq     = track.w_seq;
        rec_d.stalls  = track.wb_stalls;
        rec_d.wb_data = wb_data;          // Only valid in the write-back cycle itself
    end

    // Strobe, high once per write-back instruction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= track.w_valid;  // Bubbles give no strobe
        end
    end

    // Payload register, loads only with a strobe
    always_ff @(posedge clk) begin
        if (track.w_valid) begin
            retire <= rec_d;
        end
    end

endmodule

// File: design/stage_tracker.sv
////////////////////////////////////////////////////////////////////////////
// Follows sequence numbers through fetch, decode, execute, memory, wb
// Stall holds fetch and decode and puts a bubble into execute
// Fetch is empty only in the first cycle after reset, then always valid
// No flush or kill support
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module stage_tracker (
    input  logic                   clk,
    input  logic                   rst_n,   // Sync, active low
    input  logic                   stall,   // Level, holds fetch and decode
    output pipe_trace_pkg::track_t track
);

    logic                       f_valid_q;
    pipe_trace_pkg::seq_t       f_seq_q;
    pipe_trace_pkg::seq_t       next_seq_q;  // Seq given to the next fetch
    logic                       d_valid_q;
    pipe_trace_pkg::seq_t       d_seq_q;
    pipe_trace_pkg::stall_cnt_t d_stalls_q;
    logic                       e_valid_q;
    pipe_trace_pkg::seq_t       e_seq_q;
    pipe_trace_pkg::stall_cnt_t e_stalls_q;
    logic                       m_valid_q;
    pipe_trace_pkg::seq_t       m_seq_q;
    pipe_trace_pkg::stall_cnt_t m_stalls_q;
    logic                       w_valid_q;
    pipe_trace_pkg::seq_t       w_seq_q;
    pipe_trace_pkg::stall_cnt_t w_stalls_q;
    logic                       fetch_load;
    logic                       stall_sat;

    // An empty fetch slot fills even under stall
    assign fetch_load = !f_valid_q || !stall;
    assign stall_sat  = (d_stalls_q == pipe_trace_pkg::stall_cnt_t'(pipe_trace_pkg::stall_max));

    ////////////////////////////////////////////////////////////////////////////
    // Front end, fetch and decode hold on stall
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            f_valid_q  <= 1'b0;
            f_seq_q    <= '0;
            next_seq_q <= '0;                 // First instruction gets seq 0
        end else if (fetch_load) begin
            f_valid_q  <= 1'b1;
            f_seq_q    <= next_seq_q;
            next_seq_q <= next_seq_q + 1'b1;  // Wraps at 256
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_valid_q  <= 1'b0;
            d_seq_q    <= '0;
            d_stalls_q <= '0;
        end else if (!stall) begin
            d_valid_q  <= f_valid_q;          // Fetch moves on
            d_seq_q    <= f_seq_q;
            d_stalls_q <= '0;                 // New instruction starts unstalled
        end else if (d_valid_q && !stall_sat) begin
            d_stalls_q <= d_stalls_q + 1'b1;  // Empty decode counts nothing
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Back end, always advances
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_valid_q  <= 1'b0;
            e_seq_q    <= '0;
            e_stalls_q <= '0;
            m_valid_q  <= 1'b0;
            m_seq_q    <= '0;
            m_stalls_q <= '0;
            w_valid_q  <= 1'b0;
            w_seq_q    <= '0;
            w_stalls_q <= '0;
        end else begin
            e_valid_q  <= d_valid_q && !stall;  // Bubble while decode holds
            e_seq_q    <= d_seq_q;
            e_stalls_q <= d_stalls_q;           // Count travels with its instruction
            m_valid_q  <= e_valid_q;
            m_seq_q    <= e_seq_q;
            m_stalls_q <= e_stalls_q;
            w_valid_q  <= m_valid_q;
            w_seq_q    <= m_seq_q;
            w_stalls_q <= m_stalls_q;
        end
    end

    // Pack the view for the log and the assembler
    always_comb begin
        track.f_valid   = f_valid_q;
        track.f_seq     = f_seq_q;
        track.d_valid   = d_valid_q;
        track.d_seq     = d_seq_q;
        track.e_valid   = e_valid_q;
        track.e_seq     = e_seq_q;
        track.m_valid   = m_valid_q;
        track.m_seq     = m_seq_q;
        track.w_valid   = w_valid_q;
        track.w_seq     = w_seq_q;
        track.wb_stalls = w_stalls_q;
    end

endmodule

// File: dv/pipe_trace_asserts.sv
////////////////////////////////////////////////////////////////////////////
// Protocol checks on the retire port of pipe_trace_top
// Seq step check starts at the first strobe after reset
// Strobes in adjacent cycles are legal when instructions retire back to back
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pipe_trace_asserts (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        retire_valid,
    input pipe_trace_pkg::retire_rec_t retire
);

    pipe_trace_pkg::seq_t last_seq;  // Seq of the previous strobe
    logic                 have_last; // At least one strobe seen

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            have_last <= 1'b0;
            last_seq  <= '0;
        end else if (retire_valid) begin
            have_last <= 1'b1;
            last_seq  <= retire.seq;
        end
    end

    // Each record strobes only once so adjacent strobes differ in seq
    a_one_strobe_per_record: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_valid && $past(retire_valid)) |-> (retire.seq != $past(retire.seq)))
        else $error("retire seq %0d strobed in two cycles in a row", retire.seq);

    // Seq steps by one per strobe and wraps at 256
    a_seq_step: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_valid && have_last) |-> (retire.seq == pipe_trace_pkg::seq_t'(last_seq + 1'b1)))
        else $error("retire seq %0d does not follow %0d", retire.seq, last_seq);

    a_quiet_in_reset: assert property (@(posedge clk)
        !rst_n |=> !retire_valid)          // Nothing leaves while held in reset
        else $error("retire record left during reset");

endmodule

// File: dv/pipe_trace_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for pipe_trace_top, stimulus and expected records from file
// Cycle 0 is the first cycle with rst_n high, inputs change 1 ns after edge
// After the last stimulus line stall stays high so the pipe drains
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pipe_trace_tb;

    logic                        clk;
    logic                        rst_n;
    logic                        stall;
    pipe_trace_pkg::stage_in_t   stage_in;
    logic                        retire_valid;
    pipe_trace_pkg::retire_rec_t retire;

    logic                        stall_q [$];  // Per-cycle stall bits
    pipe_trace_pkg::stage_in_t   stim_q  [$];  // Per-cycle payloads
    pipe_trace_pkg::retire_rec_t exp_q   [$];  // Expected records, fetch order
    pipe_trace_pkg::retire_rec_t exp_rec;
    int                          errors = 0;
    int                          checks = 0;
    int                          cyc;
    int                          limit;
    logic                        timed_out;

    pipe_trace_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .stage_in     (stage_in),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    bind pipe_trace_top pipe_trace_asserts asserts_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #4 clk = ~clk;  // 8 ns period

    // One compare for every field, narrow fields zero-extended
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // File reader, C lines expand to cycles and E lines to records
    ////////////////////////////////////////////////////////////////////////////
    task automatic read_tests();
        int                          fd;
        int                          n;
        int                          st;
        logic [8*8-1:0]              tag;
        logic [8*128-1:0]            rest;
        logic [31:0]                 w [6];
        pipe_trace_pkg::stage_in_t   s;
        pipe_trace_pkg::retire_rec_t r;
        fd = $fopen("dv/pipe_trace_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open dv/pipe_trace_tests.txt");
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                void'($fgets(rest, fd));          // Rest of a comment line
            end else if (tag == "C") begin
                void'($fscanf(fd, "%d %d %h %h %h %h %h", n, st, w[0], w[1], w[2], w[3], w[4]));
                for (int i = 0; i < n; i++) begin
                    s.fetch_pc     = w[0] + i;      // Each word steps per cycle
                    s.decode_instr = w[1] + i;
                    s.exec_result  = w[2] + i;
                    s.mem_addr     = w[3] + i;
                    s.wb_data      = w[4] + i;
                    stall_q.push_back(st[0]);
                    stim_q.push_back(s);
                end
            end else if (tag == "E") begin
                void'($fscanf(fd, "%d %h %h %h %h %h %h %h",
                              n, w[5], w[0], w[1], w[2], w[3], w[4], st));
                for (int i = 0; i < n; i++) begin
                    r.seq         = pipe_trace_pkg::seq_t'(w[5] + i);  // Wraps
                    r.fetch_pc    = w[0] + i;
                    r.instr       = w[1] + i;
                    r.exec_result = w[2] + i;
                    r.mem_addr    = w[3] + i;
                    r.wb_data     = w[4] + i;
                    r.stalls      = pipe_trace_pkg::stall_cnt_t'(st);
                    exp_q.push_back(r);
                end
            end else begin
                errors++;
                $display("Unknown line tag in test file, reading stopped");
                break;
            end
        end
        $fclose(fd);
    endtask

    // Retire monitor, samples mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (rst_n && retire_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Retire record for seq %0d arrived with none expected", retire.seq);
            end else begin
                exp_rec = exp_q.pop_front();
                check_value("seq",         32'(retire.seq),    32'(exp_rec.seq));
                check_value("fetch_pc",    retire.fetch_pc,    exp_rec.fetch_pc);
                check_value("instr",       retire.instr,       exp_rec.instr);
                check_value("exec_result", retire.exec_result, exp_rec.exec_result);
                check_value("mem_addr",    retire.mem_addr,    exp_rec.mem_addr);
                check_value("wb_data",     retire.wb_data,     exp_rec.wb_data);
                check_value("stalls",      32'(retire.stalls), 32'(exp_rec.stalls));
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        stall    = 1'b0;
        stage_in = '0;
        read_tests();
        repeat (4) @(posedge clk);              // Reset over 4 edges
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < stall_q.size(); i++) begin
            stall    = stall_q[i];
            stage_in = stim_q[i];
            @(posedge clk);
            #1;
        end
        stall = 1'b1;                           // Hold front end, let back end drain
        cyc   = stall_q.size();
        limit = stall_q.size() + 20;
        while (exp_q.size() != 0 && cyc < limit) begin
            @(posedge clk);
            cyc++;
        end
        timed_out = (exp_q.size() != 0);
        if (timed_out) begin
            $display("Timeout, %0d expected retire records never arrived", exp_q.size());
        end
        for (int j = 0; j < 8; j++) begin       // Extra strobes show up here
            @(posedge clk);
        end
        $display("Checks: %0d, errors: %0d, records missing: %0d",
                 checks, errors, exp_q.size());
        if (errors == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: dv/pipe_trace_tests.txt
# C cycles stall fetch_pc decode_instr exec_result mem_addr wb_data (words step +1 per cycle)
# E records seq fetch_pc instr exec_result mem_addr wb_data stalls (all but stalls step +1)
# Stall while decode is empty, cycles 0..2
C 3 1 10000000 20000000 30000000 40000000 50000000
# Free run, cycles 3..12
C 10 0 10000003 20000003 30000003 40000003 50000003
# Three stalls on seq 9, cycles 13..15
C 3 1 1000000d 2000000d 3000000d 4000000d 5000000d
# Free run, cycles 16..25
C 10 0 10000010 20000010 30000010 40000010 50000010
# Eighteen stalls on seq 19 saturate at 15, cycles 26..43
C 18 1 1000001a 2000001a 3000001a 4000001a 5000001a
# Long free run wraps seq past 255, cycles 44..299
C 256 0 1000002c 2000002c 3000002c 4000002c 5000002c
# Final stall drains the back end, cycles 300..305
C 6 1 1000012c 2000012c 3000012c 4000012c 5000012c
# seq 0 waited in fetch from cycle 1
E 1 00 10000001 20000004 30000005 40000006 50000007 0
E 8 01 10000004 20000005 30000006 40000007 50000008 0
# seq 9 decoded last in cycle 16
E 1 09 1000000c 20000010 30000011 40000012 50000013 3
# seq 10 held in fetch, keeps first pc
E 1 0a 1000000d 20000011 30000012 40000013 50000014 0
E 8 0b 10000011 20000012 30000013 40000014 50000015 0
E 1 13 10000019 2000002c 3000002d 4000002e 5000002f f
E 1 14 1000001a 2000002d 3000002e 4000002f 50000030 0
# seq 21 through 274, wraps to 18
E 254 15 1000002d 2000002e 3000002f 40000030 50000031 0

// File: pipe_trace.f
design/pipe_trace_pkg.sv
design/stage_tracker.sv
design/payload_log.sv
design/retire_assembler.sv
design/pipe_trace_top.sv
dv/pipe_trace_asserts.sv
dv/pipe_trace_tb.sv
